/* design/spi_regs_pkg.sv */
package spi_regs_pkg;

  // frame geometry
  localparam int FRAME_BITS = 32;   // dir + addr + data
  localparam int HDR_BITS   = 8;    // dir + 7 bit address
  localparam int REG_BITS   = 24;   // register payload
  localparam int ADDR_BITS  = 7;
  localparam int SEL_BITS   = 5;    // register index part of the address
  localparam int OP_BITS    = 2;    // write operation part of the address

  typedef logic [REG_BITS-1:0]  reg_word_t;
  typedef logic [ADDR_BITS-1:0] reg_addr_t;
  typedef logic [SEL_BITS-1:0]  reg_sel_t;
  typedef logic [OP_BITS-1:0]   reg_op_t;
  typedef logic [5:0]           bit_cnt_t;   // counts up to 63, saturates

  // write operations, carried in address bits 6..5
  localparam reg_op_t OP_WRITE  = 2'd0;
  localparam reg_op_t OP_SET    = 2'd1;
  localparam reg_op_t OP_CLEAR  = 2'd2;
  localparam reg_op_t OP_TOGGLE = 2'd3;

  // register indices, address bits 4..0
  localparam reg_sel_t ADDR_LED     = 5'd7;
  localparam reg_sel_t ADDR_SPI_MUX = 5'd8;
  localparam reg_sel_t ADDR_4094    = 5'd9;

  localparam reg_word_t LED_RESET    = 24'h000015;   // 10101 on the leds
  localparam reg_word_t READ_DEFAULT = 24'd12345;    // unknown index

endpackage

/* design/spi_frame_rx.sv */
`timescale 1ns/1ps

module spi_frame_rx (
  input  logic                    cs,
  input  logic                    rst_n,
  input  logic                    sck,
  input  logic                    ss_n,
  input  logic                    mosi,
  input  spi_regs_pkg::reg_word_t rd_data,
  output logic                    miso,
  output logic                    hdr_valid,
  output spi_regs_pkg::reg_addr_t hdr_addr,
  output logic                    wr_valid,
  output spi_regs_pkg::reg_addr_t wr_addr,
  output spi_regs_pkg::reg_word_t wr_data
);

  logic [1:0] sck_sync;    // two flop synchronizers
  logic [1:0] ss_sync;
  logic [1:0] mosi_sync;
  logic       sck_prev;    // for edge detect
  logic       ss_prev;
  logic       sck_rise;
  logic       sck_fall;
  logic       ss_rise;
  logic       ss_idle;

  logic [spi_regs_pkg::FRAME_BITS-1:0] in_sr;    // mosi shift register
  logic [spi_regs_pkg::HDR_BITS-1:0]   hdr_q;    // dir + addr, captured at bit 8
  spi_regs_pkg::reg_word_t             out_sr;   // miso shifter
  spi_regs_pkg::bit_cnt_t              bit_cnt;

  always_ff @(posedge cs)
  begin
    if (!rst_n)
    begin
      sck_sync  <= 2'b00;
      ss_sync   <= 2'b11;   // deselected
      mosi_sync <= 2'b00;
      sck_prev  <= 1'b0;
      ss_prev   <= 1'b1;
    end
    else
    begin
      sck_sync  <= {sck_sync[0], sck};
      ss_sync   <= {ss_sync[0], ss_n};
      mosi_sync <= {mosi_sync[0], mosi};
      sck_prev  <= sck_sync[1];
      ss_prev   <= ss_sync[1];
    end
  end

  assign ss_idle  = ss_sync[1];
  assign sck_rise = sck_sync[1] & ~sck_prev;    // mode 0 sample edge
  assign sck_fall = ~sck_sync[1] & sck_prev;    // mode 0 launch edge
  assign ss_rise  = ss_sync[1] & ~ss_prev;      // end of frame

  // data path, no reset needed
  always_ff @(posedge cs)
  begin
    if (!ss_idle && sck_rise)
    begin
      in_sr <= {in_sr[spi_regs_pkg::FRAME_BITS-2:0], mosi_sync[1]};
      if (bit_cnt == spi_regs_pkg::bit_cnt_t'(spi_regs_pkg::HDR_BITS - 1))
        hdr_q <= {in_sr[spi_regs_pkg::HDR_BITS-2:0], mosi_sync[1]};   // 8th bit arriving
    end
    if (ss_rise)
    begin
      wr_addr <= in_sr[spi_regs_pkg::FRAME_BITS-2:spi_regs_pkg::REG_BITS];
      wr_data <= in_sr[spi_regs_pkg::REG_BITS-1:0];
    end
  end

  always_ff @(posedge cs)
  begin
    if (!rst_n)
    begin
      bit_cnt   <= '0;
      out_sr    <= '0;
      miso      <= 1'b0;
      hdr_valid <= 1'b0;
      wr_valid  <= 1'b0;
    end
    else
    begin
      hdr_valid <= 1'b0;   // strobes
      wr_valid  <= 1'b0;
      if (ss_idle)
      begin
        bit_cnt <= '0;
        out_sr  <= '0;
        miso    <= 1'b0;
        // commit only full write frames, bit 31 low means write
        if (ss_rise && bit_cnt == spi_regs_pkg::bit_cnt_t'(spi_regs_pkg::FRAME_BITS) &&
            !in_sr[spi_regs_pkg::FRAME_BITS-1])
          wr_valid <= 1'b1;
      end
      else
      begin
        if (sck_rise)
        begin
          if (bit_cnt != '1)
            bit_cnt <= bit_cnt + 1'b1;   // saturate on overlong frames
          if (bit_cnt == spi_regs_pkg::bit_cnt_t'(spi_regs_pkg::HDR_BITS - 1))
            hdr_valid <= 1'b1;
        end
        if (hdr_valid)
        begin
          // rd_data answers hdr_addr in this cycle, zeros for a write frame
          out_sr <= hdr_q[spi_regs_pkg::HDR_BITS-1] ? rd_data : '0;
        end
        else if (sck_fall)
        begin
          miso   <= out_sr[spi_regs_pkg::REG_BITS-1];   // msb first
          out_sr <= out_sr << 1;
        end
      end
    end
  end

  assign hdr_addr = hdr_q[spi_regs_pkg::HDR_BITS-2:0];

endmodule

/* design/reg_bank.sv */
`timescale 1ns/1ps

module reg_bank (
  input  logic                    cs,
  input  logic                    rst_n,
  input  spi_regs_pkg::reg_addr_t hdr_addr,
  input  logic                    wr_valid,
  input  spi_regs_pkg::reg_addr_t wr_addr,
  input  spi_regs_pkg::reg_word_t wr_data,
  output spi_regs_pkg::reg_word_t rd_data,
  output spi_regs_pkg::reg_word_t led,
  output spi_regs_pkg::reg_word_t spi_mux,
  output spi_regs_pkg::reg_word_t reg_4094,
  output logic                    wr_4094
);

  spi_regs_pkg::reg_sel_t wr_sel;
  spi_regs_pkg::reg_op_t  wr_op;
  spi_regs_pkg::reg_sel_t rd_sel;

  // one update rule for all ops, clear wins over set
  function automatic spi_regs_pkg::reg_word_t apply_op(
    input spi_regs_pkg::reg_word_t cur,
    input spi_regs_pkg::reg_op_t   op,
    input spi_regs_pkg::reg_word_t data
  );
    spi_regs_pkg::reg_word_t set_m;
    spi_regs_pkg::reg_word_t clr_m;
    spi_regs_pkg::reg_word_t tgl_m;
    set_m = '0;
    clr_m = '0;
    tgl_m = '0;
    case (op)
      spi_regs_pkg::OP_WRITE:
      begin
        set_m = data;    // replace is set ones + clear zeros
        clr_m = ~data;
      end
      spi_regs_pkg::OP_SET:   set_m = data;
      spi_regs_pkg::OP_CLEAR: clr_m = data;
      default:                tgl_m = data;   // toggle
    endcase
    return ((cur | set_m) & ~clr_m) ^ tgl_m;
  endfunction

  assign wr_sel = wr_addr[spi_regs_pkg::SEL_BITS-1:0];
  assign wr_op  = wr_addr[spi_regs_pkg::ADDR_BITS-1:spi_regs_pkg::SEL_BITS];
  assign rd_sel = hdr_addr[spi_regs_pkg::SEL_BITS-1:0];   // op bits ignored on read

  always_ff @(posedge cs)
  begin
    if (!rst_n)
    begin
      led      <= spi_regs_pkg::LED_RESET;
      spi_mux  <= '0;    // no spi device selected
      reg_4094 <= '0;
      wr_4094  <= 1'b0;
    end
    else
    begin
      wr_4094 <= 1'b0;
      if (wr_valid)
      begin
        case (wr_sel)
          spi_regs_pkg::ADDR_LED:     led     <= apply_op(led, wr_op, wr_data);
          spi_regs_pkg::ADDR_SPI_MUX: spi_mux <= apply_op(spi_mux, wr_op, wr_data);
          spi_regs_pkg::ADDR_4094:
          begin
            reg_4094 <= apply_op(reg_4094, wr_op, wr_data);
            wr_4094  <= 1'b1;   // kick the chain update
          end
          default: ;            // unknown index, write dropped
        endcase
      end
    end
  end

  // readback mux, answered in the hdr_valid cycle
  always_comb
  begin
    case (rd_sel)
      spi_regs_pkg::ADDR_LED:     rd_data = led;
      spi_regs_pkg::ADDR_SPI_MUX: rd_data = spi_mux;
      spi_regs_pkg::ADDR_4094:    rd_data = reg_4094;
      default:                    rd_data = spi_regs_pkg::READ_DEFAULT;
    endcase
  end

endmodule

/* design/sr4094_driver.sv */
`timescale 1ns/1ps

module sr4094_driver (
  input  logic                    cs,
  input  logic                    rst_n,
  input  spi_regs_pkg::reg_word_t reg_4094,
  input  logic                    wr_4094,
  output logic                    sr_data,
  output logic                    sr_clk,
  output logic                    sr_strobe,
  output logic                    sr_busy
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_LOW,      // data set up, clock low
    ST_HIGH,     // clock high, chain shifts
    ST_STROBE    // latch into the 4094 outputs
  } state_t;

  state_t                  state;
  spi_regs_pkg::reg_word_t shift_q;    // working copy of the register
  spi_regs_pkg::bit_cnt_t  bit_idx;    // bits sent so far
  logic                    pending;    // write came in mid update
  logic                    start;

  // idle start, or back to back rerun at the strobe
  assign start = (state == ST_IDLE || state == ST_STROBE) && (wr_4094 || pending);

  always_ff @(posedge cs)
  begin
    if (!rst_n)
    begin
      state   <= ST_IDLE;
      bit_idx <= '0;
      pending <= 1'b0;
    end
    else
    begin
      case (state)
        ST_IDLE:
          if (start)
          begin
            state   <= ST_LOW;
            bit_idx <= '0;
          end
        ST_LOW: state <= ST_HIGH;
        ST_HIGH:
          if (bit_idx == spi_regs_pkg::bit_cnt_t'(spi_regs_pkg::REG_BITS - 1))
            state <= ST_STROBE;   // all 24 clocked
          else
          begin
            bit_idx <= bit_idx + 1'b1;
            state   <= ST_LOW;
          end
        default:   // ST_STROBE
          if (start)
          begin
            state   <= ST_LOW;    // rerun with latest value
            bit_idx <= '0;
            pending <= 1'b0;
          end
          else
            state <= ST_IDLE;
      endcase
      if (wr_4094 && (state == ST_LOW || state == ST_HIGH))
        pending <= 1'b1;          // only one rerun, later writes fold in
    end
  end

  always_ff @(posedge cs)
  begin
    if (start)
      shift_q <= reg_4094;
    else if (state == ST_HIGH)
      shift_q <= shift_q << 1;    // next bit up for the following low phase
  end

  assign sr_busy   = (state != ST_IDLE);
  assign sr_clk    = (state == ST_HIGH);
  assign sr_strobe = (state == ST_STROBE);
  assign sr_data   = sr_busy & shift_q[spi_regs_pkg::REG_BITS-1];   // msb first

endmodule

/* design/spi_reg_top.sv */
`timescale 1ns/1ps

module spi_reg_top (
  input  logic                    cs,
  input  logic                    rst_n,
  input  logic                    sck,
  input  logic                    ss_n,
  input  logic                    mosi,
  output logic                    miso,
  output spi_regs_pkg::reg_word_t led,
  output spi_regs_pkg::reg_word_t spi_mux,
  output logic                    sr_data,
  output logic                    sr_clk,
  output logic                    sr_strobe,
  output logic                    sr_busy
);

  logic                    hdr_valid;
  spi_regs_pkg::reg_addr_t hdr_addr;
  logic                    wr_valid;
  spi_regs_pkg::reg_addr_t wr_addr;
  spi_regs_pkg::reg_word_t wr_data;
  spi_regs_pkg::reg_word_t rd_data;    // readback, combinational from the bank
  spi_regs_pkg::reg_word_t reg_4094;   // 4094 state, only to the driver
  logic                    wr_4094;

  spi_frame_rx u_frame_rx (
    .cs        (cs),
    .rst_n     (rst_n),
    .sck       (sck),
    .ss_n      (ss_n),
    .mosi      (mosi),
    .rd_data   (rd_data),
    .miso      (miso),
    .hdr_valid (hdr_valid),
    .hdr_addr  (hdr_addr),
    .wr_valid  (wr_valid),
    .wr_addr   (wr_addr),
    .wr_data   (wr_data)
  );

  reg_bank u_reg_bank (
    .cs       (cs),
    .rst_n    (rst_n),
    .hdr_addr (hdr_addr),
    .wr_valid (wr_valid),
    .wr_addr  (wr_addr),
    .wr_data  (wr_data),
    .rd_data  (rd_data),
    .led      (led),
    .spi_mux  (spi_mux),
    .reg_4094 (reg_4094),
    .wr_4094  (wr_4094)
  );

  sr4094_driver u_sr4094 (
    .cs        (cs),
    .rst_n     (rst_n),
    .reg_4094  (reg_4094),
    .wr_4094   (wr_4094),
    .sr_data   (sr_data),
    .sr_clk    (sr_clk),
    .sr_strobe (sr_strobe),
    .sr_busy   (sr_busy)
  );

endmodule

/* tests/spi_reg_checker.sv */
`timescale 1ns/1ps

module spi_reg_checker (
  input logic cs,
  input logic rst_n,
  input logic miso,
  input logic hdr_valid,
  input logic wr_valid,
  input logic wr_4094,
  input logic sr_clk,
  input logic sr_strobe,
  input logic sr_busy
);

  logic       sr_clk_q;
  logic [5:0] clk_rises;    // sr_clk rises since the last strobe
  logic       in_rst_q;     // reset seen on the previous edge
  int         n_strobe_len = 0;   // failures per property
  int         n_strobe_cnt = 0;
  int         n_overlap    = 0;
  int         n_clk_idle   = 0;
  int         n_rst_quiet  = 0;
  int         fail_cnt;

  assign fail_cnt = n_strobe_len + n_strobe_cnt + n_overlap + n_clk_idle + n_rst_quiet;

  always_ff @(posedge cs)
  begin
    in_rst_q <= !rst_n;
  end

  always_ff @(posedge cs)
  begin
    if (!rst_n)
    begin
      sr_clk_q  <= 1'b0;
      clk_rises <= '0;
    end
    else
    begin
      sr_clk_q <= sr_clk;
      if (sr_strobe)
        clk_rises <= '0;                     // next update counts from zero
      else if (sr_clk && !sr_clk_q)
        clk_rises <= clk_rises + 1'b1;
    end
  end

  a_strobe_len : assert property (@(posedge cs) disable iff (!rst_n)
    sr_strobe |=> !sr_strobe)
  else
  begin
    $error("sr_strobe held longer than one cycle");
    n_strobe_len++;
  end

  a_strobe_cnt : assert property (@(posedge cs) disable iff (!rst_n)
    sr_strobe |-> clk_rises == 6'd24)
  else
  begin
    $error("sr_strobe after %0d sr_clk rises", clk_rises);
    n_strobe_cnt++;
  end

  a_overlap : assert property (@(posedge cs) disable iff (!rst_n)
    !(wr_valid && hdr_valid))
  else
  begin
    $error("wr_valid and hdr_valid high together");
    n_overlap++;
  end

  a_clk_idle : assert property (@(posedge cs) disable iff (!rst_n)
    !sr_busy |-> !sr_clk)
  else
  begin
    $error("sr_clk high while the 4094 driver is idle");
    n_clk_idle++;
  end

  // held reset, every strobe and level output low
  a_rst_quiet : assert property (@(posedge cs)
    (in_rst_q && !rst_n) |->
      !(miso || hdr_valid || wr_valid || wr_4094 || sr_clk || sr_strobe || sr_busy))
  else
  begin
    $error("outputs active during reset");
    n_rst_quiet++;
  end

endmodule

bind spi_reg_top spi_reg_checker chk_i (
  .cs        (cs),
  .rst_n     (rst_n),
  .miso      (miso),
  .hdr_valid (hdr_valid),
  .wr_valid  (wr_valid),
  .wr_4094   (wr_4094),
  .sr_clk    (sr_clk),
  .sr_strobe (sr_strobe),
  .sr_busy   (sr_busy)
);

/* tests/tb_spi_reg_top.sv */
`timescale 1ns/1ps

module tb_spi_reg_top;

  localparam int RESET_CYCLES = 16;
  localparam int N_FRAMES     = 20;     // spi frames over all tests
  localparam int FRAME_CYCLES = 400;    // watchdog budget per frame
  localparam int SLACK_CYCLES = 2000;
  localparam int HALF_BIT     = 5;      // cs cycles per sck level

  logic                    cs = 1'b0;
  logic                    rst_n;
  logic                    sck;
  logic                    ss_n;
  logic                    mosi;
  logic                    miso;
  spi_regs_pkg::reg_word_t led;
  spi_regs_pkg::reg_word_t spi_mux;
  logic                    sr_data;
  logic                    sr_clk;
  logic                    sr_strobe;
  logic                    sr_busy;

  integer                  seed = 32'h8b6449ad;
  int                      errors = 0;
  int                      errors_at_start = 0;
  int                      tests_run = 0;
  int                      tests_failed = 0;
  spi_regs_pkg::reg_word_t m_led = spi_regs_pkg::LED_RESET;   // register models
  spi_regs_pkg::reg_word_t m_mux = '0;
  spi_regs_pkg::reg_word_t m_4094 = '0;
  spi_regs_pkg::reg_word_t inject_data = '0;
  logic [23:0]             chain_sr = '0;      // 4094 chain model
  spi_regs_pkg::reg_word_t chain_latch = '0;
  int                      strobe_cnt = 0;

  spi_reg_top dut_i (
    .cs        (cs),
    .rst_n     (rst_n),
    .sck       (sck),
    .ss_n      (ss_n),
    .mosi      (mosi),
    .miso      (miso),
    .led       (led),
    .spi_mux   (spi_mux),
    .sr_data   (sr_data),
    .sr_clk    (sr_clk),
    .sr_strobe (sr_strobe),
    .sr_busy   (sr_busy)
  );

  always #5 cs = ~cs;

  always @(posedge sr_clk) chain_sr <= {chain_sr[22:0], sr_data};   // shift stage

  always @(posedge sr_strobe)
  begin
    chain_latch <= chain_sr;   // storage register of the chain
    strobe_cnt  <= strobe_cnt + 1;
  end

  function automatic spi_regs_pkg::reg_word_t rand_word();
    logic [31:0] r;
    r = $random(seed);
    return r[23:0];
  endfunction

  function automatic logic [31:0] make_frame(input logic rd, input spi_regs_pkg::reg_op_t op,
                                             input spi_regs_pkg::reg_sel_t sel,
                                             input spi_regs_pkg::reg_word_t data);
    return {rd, op, sel, data};
  endfunction

  // expected register value after a write
  function automatic spi_regs_pkg::reg_word_t model_op(input spi_regs_pkg::reg_word_t cur,
                                                       input spi_regs_pkg::reg_op_t op,
                                                       input spi_regs_pkg::reg_word_t data);
    case (op)
      spi_regs_pkg::OP_WRITE: return data;
      spi_regs_pkg::OP_SET:   return cur | data;
      spi_regs_pkg::OP_CLEAR: return cur & ~data;
      default:                return cur ^ data;
    endcase
  endfunction

  function automatic int total_errors();
    return errors + dut_i.chk_i.fail_cnt;
  endfunction

  task automatic wait_cycles(input int n);
    repeat (n) @(posedge cs);
    #1;                        // drive point after the edge
  endtask

  task automatic check_word(input string what, input spi_regs_pkg::reg_word_t got,
                            input spi_regs_pkg::reg_word_t exp);
    assert (got === exp)
    else
    begin
      $display("FAILED at %0t ns: %s is %h, expected %h", $time, what, got, exp);
      errors++;
    end
  endtask

  task automatic check_count(input string what, input int got, input int exp);
    assert (got == exp)
    else
    begin
      $display("FAILED at %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
      errors++;
    end
  endtask

  task automatic start_test();
    errors_at_start = total_errors();
  endtask

  task automatic finish_test(input string name);
    int n;
    n = total_errors() - errors_at_start;
    tests_run++;
    if (n != 0)
      tests_failed++;
    $display("test %-12s %s (%0d errors)", name, (n == 0) ? "ok" : "FAIL", n);
  endtask

  // mode 0 master sending msb first from bit nbits-1
  task automatic spi_transfer(input logic [39:0] bits, input int nbits,
                              output spi_regs_pkg::reg_word_t rd);
    logic [39:0] sr;
    sr   = bits << (40 - nbits);
    rd   = '0;
    ss_n = 1'b0;
    wait_cycles(HALF_BIT);
    for (int i = 0; i < nbits; i++)
    begin
      mosi = sr[39];
      sr   = sr << 1;
      wait_cycles(HALF_BIT);              // sck low
      if (i >= 8 && i < 32)
        rd = {rd[22:0], miso};            // data bits on rises 9..32
      sck = 1'b1;
      wait_cycles(HALF_BIT);
      sck = 1'b0;
    end
    wait_cycles(HALF_BIT);
    ss_n = 1'b1;
    wait_cycles(8);                       // sync, commit and idle gap
  endtask

  task automatic write_reg(input spi_regs_pkg::reg_op_t op, input spi_regs_pkg::reg_sel_t sel,
                           input spi_regs_pkg::reg_word_t data);
    spi_regs_pkg::reg_word_t rd;
    spi_transfer({8'h00, make_frame(1'b0, op, sel, data)}, 32, rd);
    case (sel)
      spi_regs_pkg::ADDR_LED:     m_led  = model_op(m_led, op, data);
      spi_regs_pkg::ADDR_SPI_MUX: m_mux  = model_op(m_mux, op, data);
      spi_regs_pkg::ADDR_4094:    m_4094 = model_op(m_4094, op, data);
      default: ;
    endcase
  endtask

  task automatic read_check(input spi_regs_pkg::reg_sel_t sel,
                            input spi_regs_pkg::reg_word_t exp, input string what);
    spi_regs_pkg::reg_word_t rd;
    spi_transfer({8'h00, make_frame(1'b1, spi_regs_pkg::OP_WRITE, sel, '0)}, 32, rd);
    check_word(what, rd, exp);
  endtask

  task automatic wait_chain_idle();
    wait_cycles(1);
    while (sr_busy)
      wait_cycles(1);
  endtask

  // a frame is far longer than one chain update, so a second write within
  // the update goes straight onto the bank's write port
  task automatic inject_4094_write(input spi_regs_pkg::reg_word_t data);
    inject_data = data;
    force dut_i.wr_addr  = {spi_regs_pkg::OP_WRITE, spi_regs_pkg::ADDR_4094};
    force dut_i.wr_data  = inject_data;
    force dut_i.wr_valid = 1'b1;
    wait_cycles(1);
    force dut_i.wr_valid = 1'b0;
    wait_cycles(1);
    release dut_i.wr_valid;
    release dut_i.wr_addr;
    release dut_i.wr_data;
    m_4094 = data;
  endtask

  initial
  begin
    spi_regs_pkg::reg_word_t rd;
    spi_regs_pkg::reg_word_t first;
    spi_regs_pkg::reg_word_t second;
    logic [31:0]             frame;
    int                      n0;
    rst_n = 1'b0;
    sck   = 1'b0;
    ss_n  = 1'b1;
    mosi  = 1'b0;
    repeat (RESET_CYCLES) @(posedge cs);
    #1;
    rst_n = 1'b1;
    wait_cycles(4);

    start_test();
    check_word("led", led, 24'h000015);
    check_word("spi_mux", spi_mux, '0);
    check_word("4094 chain", chain_latch, '0);
    read_check(spi_regs_pkg::ADDR_LED, 24'h000015, "led readback");
    finish_test("reset");

    start_test();
    write_reg(spi_regs_pkg::OP_WRITE, spi_regs_pkg::ADDR_LED, rand_word());
    check_word("led", led, m_led);
    write_reg(spi_regs_pkg::OP_WRITE, spi_regs_pkg::ADDR_SPI_MUX, rand_word());
    check_word("spi_mux", spi_mux, m_mux);
    write_reg(spi_regs_pkg::OP_WRITE, spi_regs_pkg::ADDR_4094, rand_word());
    wait_chain_idle();
    read_check(spi_regs_pkg::ADDR_LED, m_led, "led readback");
    read_check(spi_regs_pkg::ADDR_SPI_MUX, m_mux, "spi_mux readback");
    read_check(spi_regs_pkg::ADDR_4094, m_4094, "4094 readback");
    read_check(5'd20, 24'd12345, "unknown index readback");
    finish_test("replace");

    start_test();
    for (int k = 1; k < 4; k++)
    begin
      write_reg(spi_regs_pkg::reg_op_t'(k), spi_regs_pkg::ADDR_LED, rand_word());
      check_word("led after bit op", led, m_led);
      write_reg(spi_regs_pkg::reg_op_t'(k), spi_regs_pkg::ADDR_SPI_MUX, rand_word());
      check_word("spi_mux after bit op", spi_mux, m_mux);
    end
    read_check(spi_regs_pkg::ADDR_LED, m_led, "led readback");
    read_check(spi_regs_pkg::ADDR_SPI_MUX, m_mux, "spi_mux readback");
    finish_test("bitwise");

    start_test();
    n0    = strobe_cnt;
    frame = make_frame(1'b0, spi_regs_pkg::OP_WRITE, spi_regs_pkg::ADDR_LED, ~m_led);
    spi_transfer({9'h000, frame[31:1]}, 31, rd);          // one bit short
    frame = make_frame(1'b0, spi_regs_pkg::OP_WRITE, spi_regs_pkg::ADDR_SPI_MUX, ~m_mux);
    spi_transfer({7'h00, frame, 1'b0}, 33, rd);           // one bit extra
    frame = make_frame(1'b1, spi_regs_pkg::OP_TOGGLE, spi_regs_pkg::ADDR_4094, rand_word());
    spi_transfer({8'h00, frame}, 32, rd);
    check_word("4094 read with toggle op", rd, m_4094);
    wait_chain_idle();                                    // a committed read would run the chain
    check_word("led", led, m_led);
    check_word("spi_mux", spi_mux, m_mux);
    check_count("4094 strobes", strobe_cnt, n0);
    finish_test("frame_len");

    start_test();
    write_reg(spi_regs_pkg::OP_WRITE, spi_regs_pkg::ADDR_4094, rand_word());
    wait_chain_idle();
    check_word("4094 chain", chain_latch, m_4094);
    finish_test("chain");

    start_test();
    n0     = strobe_cnt;
    first  = rand_word();
    second = rand_word();
    inject_4094_write(first);
    wait_cycles(10);
    check_count("sr_busy mid update", int'(sr_busy), 1);
    inject_4094_write(second);
    wait_chain_idle();
    check_word("4094 chain after rerun", chain_latch, second);
    check_count("4094 strobes", strobe_cnt, n0 + 2);
    finish_test("backpressure");

    $display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, total_errors());
    if (total_errors() == 0)
      $display("Test completed successfully");
    else
      $display("Test failed");
    $finish;
  end

  initial
  begin
    repeat (RESET_CYCLES + N_FRAMES * FRAME_CYCLES + SLACK_CYCLES) @(posedge cs);
    $display("timeout: the tests did not finish within the cycle budget");
    $display("Test failed");
    $finish;
  end

endmodule

/* src.f */
design/spi_regs_pkg.sv
design/spi_frame_rx.sv
design/reg_bank.sv
design/sr4094_driver.sv
design/spi_reg_top.sv
tests/spi_reg_checker.sv
tests/tb_spi_reg_top.sv

/* Makefile */
# Verilator build and run for the SPI register block

VERILATOR ?= verilator
TOP       ?= tb_spi_reg_top
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps
RUN_ARGS  ?= +verilator+error+limit+1000
PASS_MSG  ?= Test completed successfully

SIM := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# the run passes only if the pass message shows up as a line of its own
run: compile
	@out="$$($(SIM) $(RUN_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
